/* all.f */
+incdir+include
rtl/id_pkg.sv
rtl/regfile.sv
rtl/id_decoder.sv
rtl/id_operand_unit.sv
rtl/id_branch_unit.sv
rtl/id_stage.sv
verification/id_stage_props.sv
verification/id_stage_tb.sv

/* verification/id_stage_tb.sv */
`timescale 1ns/1ps
`include "id_consts.svh"

module id_stage_tb;

    localparam int NUM_TESTS  = 150;
    localparam int WAIT_LIMIT = 40;

    logic              clk;
    logic              reset;
    logic              fs_to_ds_valid;
    id_pkg::fs_to_ds_t fs_to_ds_bus;
    logic              es_allowin;
    id_pkg::es_fwd_t   es_fwd;
    id_pkg::reg_wr_t   ms_fwd;
    id_pkg::reg_wr_t   ws_wr;
    logic              ds_allowin;
    logic              ds_to_es_valid;
    id_pkg::ds_to_es_t ds_to_es_bus;
    id_pkg::br_t       br;

    logic [15:0]         lfsr = 16'd19;
    logic [`ID_XLEN-1:0] shadow [`ID_NUM_REGS];
    int                  tests = 0;
    int                  checks = 0;
    int                  errors = 0;
    bit                  timed_out = 1'b0;

    id_stage DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[0] ^ lfsr[2] ^ lfsr[3] ^ lfsr[5], lfsr[15:1]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // funct code and alu operation of register ALU kinds 0 to 10
    function automatic logic [9:0] r_code(input int kind);
        case (kind)
            0: return {6'h21, id_pkg::ALU_ADD};
            1: return {6'h23, id_pkg::ALU_SUB};
            2: return {6'h2a, id_pkg::ALU_SLT};
            3: return {6'h2b, id_pkg::ALU_SLTU};
            4: return {6'h24, id_pkg::ALU_AND};
            5: return {6'h25, id_pkg::ALU_OR};
            6: return {6'h26, id_pkg::ALU_XOR};
            7: return {6'h27, id_pkg::ALU_NOR};
            8: return {6'h00, id_pkg::ALU_SLL};
            9: return {6'h02, id_pkg::ALU_SRL};
            default: return {6'h03, id_pkg::ALU_SRA};
        endcase
    endfunction

    function automatic logic [`ID_XLEN-1:0] make_inst(input int kind);
        logic [`ID_XLEN-1:0] w;
        w = rand_bits(32);
        case (kind)
            11: w[31:26] = 6'h09;
            12: w[31:21] = {6'h0f, 5'd0};
            13: w[31:26] = 6'h23;
            14: w[31:26] = 6'h2b;
            15: w[31:26] = 6'h04;
            16: w[31:26] = 6'h05;
            17: w[31:26] = 6'h03;
            18: begin
                w[31:26] = 6'h00;
                w[5:0]   = 6'h08;
            end
            default: begin
                w[31:26] = 6'h00;
                w[5:0]   = r_code(kind) >> 4;
                // shifts need rs = 0, the others a zero shamt
                if (kind >= 8) w[25:21] = 5'd0;
                else w[10:6] = 5'd0;
            end
        endcase
        // equal operands half of the time
        if ((kind == 15 || kind == 16) && rand_bits(1)) w[20:16] = w[25:21];
        return w;
    endfunction

    function automatic logic [`ID_REG_ADDR_W-1:0] pick_dest(input logic [`ID_XLEN-1:0] inst);
        logic [1:0] sel;
        sel = rand_bits(2);
        case (sel)
            2'd0: return inst[25:21];
            2'd1: return inst[20:16];
            default: return rand_bits(5);
        endcase
    endfunction

    function automatic logic [`ID_XLEN-1:0] fwd_value(input logic [`ID_REG_ADDR_W-1:0] idx);
        if (idx == 0) return '0;
        if (es_fwd.we && es_fwd.dest == idx) return es_fwd.data;
        if (ms_fwd.we && ms_fwd.addr == idx) return ms_fwd.data;
        if (ws_wr.we && ws_wr.addr == idx) return ws_wr.data;
        return shadow[idx];
    endfunction

    function automatic id_pkg::ds_to_es_t expect_bus(input int kind,
            input logic [`ID_XLEN-1:0] inst, input logic [`ID_XLEN-1:0] pc,
            input logic [`ID_XLEN-1:0] rsv, input logic [`ID_XLEN-1:0] rtv);
        id_pkg::ds_to_es_t b;
        b = '0;
        b.dest     = inst[15:11];
        b.imm      = inst[15:0];
        b.rs_value = rsv;
        b.rt_value = rtv;
        b.pc       = pc;
        if (kind <= 10) begin
            b.alu_op     = id_pkg::alu_op_e'(r_code(kind) & 10'h00f);
            b.src1_is_sa = (kind >= 8);
            b.gr_we      = 1'b1;
        end
        // addiu, lui and lw write rt
        if (kind >= 11 && kind <= 13) begin
            b.dest  = inst[20:16];
            b.gr_we = 1'b1;
        end
        b.src2_is_imm = (kind >= 11 && kind <= 14);
        b.load_op     = (kind == 13);
        b.mem_we      = (kind == 14);
        if (kind == 12) b.alu_op = id_pkg::ALU_LUI;
        if (kind == 17) begin
            b.src1_is_pc = 1'b1;
            b.src2_is_8  = 1'b1;
            b.gr_we      = 1'b1;
            b.dest       = `ID_RA_REG;
        end
        return b;
    endfunction

    task automatic check_value(input string name, input logic [127:0] expected,
            input logic [127:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("ERROR %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout, no %s within %0d cycles", what, WAIT_LIMIT);
    endtask

    task automatic run_test(input int t, output bit stuck);
        int                  kind;
        int                  n;
        logic [`ID_XLEN-1:0] inst;
        logic [`ID_XLEN-1:0] pc;
        logic [`ID_XLEN-1:0] fpc;
        logic [`ID_XLEN-1:0] rsv;
        logic [`ID_XLEN-1:0] rtv;
        logic [`ID_XLEN-1:0] exp_target;
        logic                exp_taken;
        logic                blocked;
        id_pkg::ds_to_es_t   exp_bus;

        stuck = 1'b0;
        kind = rand_bits(5) % 19;
        inst = make_inst(kind);
        pc   = rand_bits(30) << 2;
        fpc  = pc + 4;
        es_fwd.we           = rand_bits(1);
        es_fwd.dest         = pick_dest(inst);
        es_fwd.data         = rand_bits(32);
        es_fwd.load_pending = es_fwd.we && (rand_bits(2) == 0);
        ms_fwd.we   = rand_bits(1);
        ms_fwd.addr = pick_dest(inst);
        ms_fwd.data = rand_bits(32);
        ws_wr.we    = rand_bits(1);
        ws_wr.addr  = pick_dest(inst);
        ws_wr.data  = rand_bits(32);
        if (ws_wr.we) shadow[ws_wr.addr] = ws_wr.data;
        es_allowin = rand_bits(1);

        rsv = fwd_value(inst[25:21]);
        rtv = fwd_value(inst[20:16]);
        blocked = es_fwd.load_pending
                  && (es_fwd.dest == inst[25:21] || es_fwd.dest == inst[20:16]);
        exp_bus = expect_bus(kind, inst, pc, rsv, rtv);
        exp_taken = (kind == 15) ? (rsv == rtv) :
                    (kind == 16) ? (rsv != rtv) : (kind >= 17);
        exp_target = (kind == 17) ? {fpc[31:28], inst[25:0], 2'b00} :
                     (kind == 18) ? rsv :
                     fpc + {{14{inst[15]}}, inst[15:0], 2'b00};

        fs_to_ds_valid    = 1'b1;
        fs_to_ds_bus.inst = inst;
        fs_to_ds_bus.pc   = pc;
        n = 0;
        @(negedge clk);
        while (!ds_allowin && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!ds_allowin) begin
            report_timeout("acceptance of the instruction");
            stuck = 1'b1;
            return;
        end
        @(posedge clk);
        #2;
        fs_to_ds_valid = 1'b0;
        // fetch has moved on to the delay slot
        fs_to_ds_bus.pc = fpc;

        @(negedge clk);
        check_value("ds_to_es_bus", exp_bus, ds_to_es_bus);
        check_value("ds_to_es_valid", !blocked, ds_to_es_valid);
        check_value("ds_allowin", !blocked && es_allowin, ds_allowin);
        check_value("br.stall", kind >= 15, br.stall);
        check_value("br.taken", exp_taken, br.taken);
        if (kind >= 15) check_value("br.target", exp_target, br.target);

        if (blocked) begin
            repeat (1 + rand_bits(2)) begin
                @(negedge clk);
                check_value("ds_to_es_valid", 1'b0, ds_to_es_valid);
                check_value("ds_allowin", 1'b0, ds_allowin);
            end
            @(posedge clk);
            #2 es_fwd.load_pending = 1'b0;
            @(negedge clk);
        end

        n = 0;
        while (!(ds_to_es_valid && es_allowin) && n < WAIT_LIMIT) begin
            @(posedge clk);
            #2 es_allowin = rand_bits(1);
            @(negedge clk);
            n++;
        end
        if (!(ds_to_es_valid && es_allowin)) begin
            report_timeout("delivery to the execute stage");
            stuck = 1'b1;
            return;
        end
        check_value("ds_to_es_bus", exp_bus, ds_to_es_bus);
        @(posedge clk);
        #2;
        tests++;
        $display("test %0d done, kind %0d inst %h blocked %0d", t, kind, inst, blocked);
    endtask

    initial begin
        reset          = 1'b1;
        fs_to_ds_valid = 1'b0;
        fs_to_ds_bus   = '0;
        es_allowin     = 1'b0;
        es_fwd         = '0;
        ms_fwd         = '0;
        ws_wr          = '0;
        repeat (4) @(posedge clk);
        #2 reset = 1'b0;
        // known contents in every register first
        for (int r = 0; r < `ID_NUM_REGS; r++) begin
            ws_wr.we   = 1'b1;
            ws_wr.addr = 5'(r);
            ws_wr.data = rand_bits(32);
            shadow[r]  = ws_wr.data;
            @(posedge clk);
            #2;
        end
        ws_wr = '0;
        for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
            run_test(t, timed_out);
        end
        $display("tests %0d, checks %0d, errors %0d, property failures %0d",
                 tests, checks, errors, DUT.u_props.failures);
        if (!timed_out && errors == 0 && DUT.u_props.failures == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* verification/id_stage_props.sv */
`timescale 1ns/1ps

module id_stage_props (
    input logic              clk,
    input logic              reset,
    input logic              es_allowin,
    input logic              ds_valid,
    input logic              ds_allowin,
    input logic              ds_to_es_valid,
    input id_pkg::ds_to_es_t ds_to_es_bus,
    input id_pkg::br_t       br
);

    int unsigned failures = 0;

    // quiet outputs through reset and one cycle beyond
    a_reset_quiet: assert property (@(posedge clk)
        reset |=> !ds_to_es_valid && !br.stall && !br.taken)
    else begin
        failures++;
        $error("outputs active during or right after reset");
    end

    a_taken_stall: assert property (@(posedge clk) disable iff (reset)
        br.taken |-> br.stall)
    else begin
        failures++;
        $error("branch taken without stall");
    end

    // instruction held, either blocked or pushed back
    a_held_no_allowin: assert property (@(posedge clk) disable iff (reset)
        ds_valid && !(ds_to_es_valid && es_allowin) |-> !ds_allowin)
    else begin
        failures++;
        $error("allowin high while an instruction is held");
    end

    a_held_bus_stable: assert property (@(posedge clk) disable iff (reset)
        ds_valid && !(ds_to_es_valid && es_allowin) |=> $stable(ds_to_es_bus))
    else begin
        failures++;
        $error("execute bus changed while the instruction was held");
    end

    a_valid_kept: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid && !es_allowin |=> ds_to_es_valid)
    else begin
        failures++;
        $error("valid to execute dropped under back-pressure");
    end

endmodule

bind id_stage id_stage_props u_props (
    .clk            (clk),
    .reset          (reset),
    .es_allowin     (es_allowin),
    .ds_valid       (ds_valid),
    .ds_allowin     (ds_allowin),
    .ds_to_es_valid (ds_to_es_valid),
    .ds_to_es_bus   (ds_to_es_bus),
    .br             (br)
);

/* rtl/id_stage.sv */
`timescale 1ns/1ps
`include "id_consts.svh"

module id_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               fs_to_ds_valid,
    input  id_pkg::fs_to_ds_t  fs_to_ds_bus,
    input  logic               es_allowin,
    input  id_pkg::es_fwd_t    es_fwd,
    input  id_pkg::reg_wr_t    ms_fwd,
    input  id_pkg::reg_wr_t    ws_wr,
    output logic               ds_allowin,
    output logic               ds_to_es_valid,
    output id_pkg::ds_to_es_t  ds_to_es_bus,
    output id_pkg::br_t        br
);

    logic                ds_valid;
    logic                ds_ready_go;
    id_pkg::fs_to_ds_t   fs_to_ds_r;
    id_pkg::decode_t     dec;
    logic [`ID_XLEN-1:0] rs_value;
    logic [`ID_XLEN-1:0] rt_value;

    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            fs_to_ds_r <= fs_to_ds_bus;
        end
    end

    id_decoder u_decoder (
        .inst (fs_to_ds_r.inst),
        .dec  (dec)
    );

    id_operand_unit u_operand_unit (
        .clk      (clk),
        .rs       (dec.rs),
        .rt       (dec.rt),
        .es_fwd   (es_fwd),
        .ms_fwd   (ms_fwd),
        .ws_wr    (ws_wr),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .ready_go (ds_ready_go)
    );

    // target base is the pc now in fetch, i.e. the delay slot
    id_branch_unit u_branch_unit (
        .dec      (dec),
        .rs_value (rs_value),
        .rt_value (rt_value),
        .ds_valid (ds_valid),
        .fetch_pc (fs_to_ds_bus.pc),
        .br       (br)
    );

    always_comb begin
        ds_to_es_bus.alu_op      = dec.alu_op;
        ds_to_es_bus.src1_is_sa  = dec.src1_is_sa;
        ds_to_es_bus.src1_is_pc  = dec.src1_is_pc;
        ds_to_es_bus.src2_is_imm = dec.src2_is_imm;
        ds_to_es_bus.src2_is_8   = dec.src2_is_8;
        ds_to_es_bus.load_op     = dec.load_op;
        ds_to_es_bus.gr_we       = dec.gr_we;
        ds_to_es_bus.mem_we      = dec.mem_we;
        ds_to_es_bus.dest        = dec.dest;
        ds_to_es_bus.imm         = dec.imm;
        ds_to_es_bus.rs_value    = rs_value;
        ds_to_es_bus.rt_value    = rt_value;
        ds_to_es_bus.pc          = fs_to_ds_r.pc;
    end

endmodule

/* rtl/id_branch_unit.sv */
`timescale 1ns/1ps
`include "id_consts.svh"

module id_branch_unit (
    input  id_pkg::decode_t     dec,
    input  logic [`ID_XLEN-1:0] rs_value,
    input  logic [`ID_XLEN-1:0] rt_value,
    input  logic                ds_valid,
    input  logic [`ID_XLEN-1:0] fetch_pc,
    output id_pkg::br_t         br
);

    logic                rs_eq_rt;
    logic                cond;
    logic [`ID_XLEN-1:0] branch_offset;
    logic [`ID_XLEN-1:0] branch_target;
    logic [`ID_XLEN-1:0] jump_target;

    assign rs_eq_rt = (rs_value == rt_value);

    // word offset relative to the delay slot
    assign branch_offset = {{(`ID_XLEN - `ID_IMM_W - 2){dec.imm[`ID_IMM_W-1]}}, dec.imm, 2'b00};
    assign branch_target = fetch_pc + branch_offset;
    assign jump_target   = {fetch_pc[`ID_XLEN-1:`ID_JIDX_W+2], dec.jidx, 2'b00};

    always_comb begin
        case (dec.branch)
            id_pkg::BR_BEQ: begin
                cond      = rs_eq_rt;
                br.target = branch_target;
            end
            id_pkg::BR_BNE: begin
                cond      = !rs_eq_rt;
                br.target = branch_target;
            end
            id_pkg::BR_JAL: begin
                cond      = 1'b1;
                br.target = jump_target;
            end
            id_pkg::BR_JR: begin
                cond      = 1'b1;
                br.target = rs_value;
            end
            default: begin
                cond      = 1'b0;
                br.target = branch_target;
            end
        endcase
        br.stall = ds_valid && (dec.branch != id_pkg::BR_NONE);
        br.taken = ds_valid && cond;
    end

endmodule

/* rtl/id_operand_unit.sv */
`timescale 1ns/1ps
`include "id_consts.svh"

module id_operand_unit (
    input  logic                      clk,
    input  logic [`ID_REG_ADDR_W-1:0] rs,
    input  logic [`ID_REG_ADDR_W-1:0] rt,
    input  id_pkg::es_fwd_t           es_fwd,
    input  id_pkg::reg_wr_t           ms_fwd,
    input  id_pkg::reg_wr_t           ws_wr,
    output logic [`ID_XLEN-1:0]       rs_value,
    output logic [`ID_XLEN-1:0]       rt_value,
    output logic                      ready_go
);

    logic [`ID_XLEN-1:0] rf_rdata1;
    logic [`ID_XLEN-1:0] rf_rdata2;
    logic                load_use;

    // youngest producer wins, register file last
    function automatic logic [`ID_XLEN-1:0] pick_operand(
        input logic [`ID_REG_ADDR_W-1:0] idx,
        input logic [`ID_XLEN-1:0]       rf_data,
        input id_pkg::es_fwd_t           es,
        input id_pkg::reg_wr_t           ms,
        input id_pkg::reg_wr_t           ws
    );
        logic                nonzero;
        logic [`ID_XLEN-1:0] value;
        nonzero = (idx != '0);
        if (nonzero && es.we && es.dest == idx) begin
            value = es.data;
        end else if (nonzero && ms.we && ms.addr == idx) begin
            value = ms.data;
        end else if (nonzero && ws.we && ws.addr == idx) begin
            value = ws.data;
        end else begin
            value = rf_data;
        end
        return value;
    endfunction

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rs),
        .raddr2 (rt),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (ws_wr)
    );

    assign rs_value = pick_operand(rs, rf_rdata1, es_fwd, ms_fwd, ws_wr);
    assign rt_value = pick_operand(rt, rf_rdata2, es_fwd, ms_fwd, ws_wr);

    // load data not ready until memory stage
    assign load_use = es_fwd.load_pending && (es_fwd.dest == rs || es_fwd.dest == rt);
    assign ready_go = !load_use;

endmodule

/* rtl/id_decoder.sv */
`timescale 1ns/1ps
`include "id_consts.svh"

module id_decoder (
    input  logic [`ID_XLEN-1:0] inst,
    output id_pkg::decode_t     dec
);

    localparam logic [`ID_REG_ADDR_W-1:0] RA_REG = `ID_RA_REG;

    id_pkg::opcode_e           op;
    id_pkg::funct_e            funct;
    id_pkg::alu_op_e           r_alu_op;
    logic [`ID_REG_ADDR_W-1:0] rs;
    logic [`ID_REG_ADDR_W-1:0] rt;
    logic [`ID_REG_ADDR_W-1:0] rd;
    logic [`ID_REG_ADDR_W-1:0] sa;
    logic                      shamt_zero;
    logic                      rs_zero;
    logic                      dst_is_r31;
    logic                      dst_is_rt;

    assign op    = id_pkg::opcode_e'(inst[31:26]);
    assign rs    = inst[25:21];
    assign rt    = inst[20:16];
    assign rd    = inst[15:11];
    assign sa    = inst[10:6];
    assign funct = id_pkg::funct_e'(inst[5:0]);

    assign shamt_zero = (sa == '0);
    assign rs_zero    = (rs == '0);

    // alu operation for the special opcode
    always_comb begin
        case (funct)
            id_pkg::FN_ADDU: r_alu_op = id_pkg::ALU_ADD;
            id_pkg::FN_SUBU: r_alu_op = id_pkg::ALU_SUB;
            id_pkg::FN_SLT:  r_alu_op = id_pkg::ALU_SLT;
            id_pkg::FN_SLTU: r_alu_op = id_pkg::ALU_SLTU;
            id_pkg::FN_AND:  r_alu_op = id_pkg::ALU_AND;
            id_pkg::FN_OR:   r_alu_op = id_pkg::ALU_OR;
            id_pkg::FN_XOR:  r_alu_op = id_pkg::ALU_XOR;
            id_pkg::FN_NOR:  r_alu_op = id_pkg::ALU_NOR;
            id_pkg::FN_SLL:  r_alu_op = id_pkg::ALU_SLL;
            id_pkg::FN_SRL:  r_alu_op = id_pkg::ALU_SRL;
            id_pkg::FN_SRA:  r_alu_op = id_pkg::ALU_SRA;
            default:         r_alu_op = id_pkg::ALU_ADD;
        endcase
    end

    always_comb begin
        // unrecognised words fall through with nothing enabled
        dec.alu_op      = id_pkg::ALU_ADD;
        dec.src1_is_sa  = 1'b0;
        dec.src1_is_pc  = 1'b0;
        dec.src2_is_imm = 1'b0;
        dec.src2_is_8   = 1'b0;
        dec.load_op     = 1'b0;
        dec.gr_we       = 1'b0;
        dec.mem_we      = 1'b0;
        dec.branch      = id_pkg::BR_NONE;
        dec.imm         = inst[`ID_IMM_W-1:0];
        dec.rs          = rs;
        dec.rt          = rt;
        dec.jidx        = inst[`ID_JIDX_W-1:0];
        dst_is_r31      = 1'b0;
        dst_is_rt       = 1'b0;

        case (op)
            id_pkg::OP_SPECIAL: begin
                case (funct)
                    id_pkg::FN_ADDU, id_pkg::FN_SUBU, id_pkg::FN_SLT, id_pkg::FN_SLTU,
                    id_pkg::FN_AND, id_pkg::FN_OR, id_pkg::FN_XOR, id_pkg::FN_NOR: begin
                        if (shamt_zero) begin
                            dec.alu_op = r_alu_op;
                            dec.gr_we  = 1'b1;
                        end
                    end
                    id_pkg::FN_SLL, id_pkg::FN_SRL, id_pkg::FN_SRA: begin
                        if (rs_zero) begin
                            dec.alu_op     = r_alu_op;
                            dec.src1_is_sa = 1'b1;
                            dec.gr_we      = 1'b1;
                        end
                    end
                    id_pkg::FN_JR: dec.branch = id_pkg::BR_JR;
                    default: ;
                endcase
            end
            id_pkg::OP_ADDIU: begin
                dec.src2_is_imm = 1'b1;
                dec.gr_we       = 1'b1;
                dst_is_rt       = 1'b1;
            end
            id_pkg::OP_LUI: begin
                if (rs_zero) begin
                    dec.alu_op      = id_pkg::ALU_LUI;
                    dec.src2_is_imm = 1'b1;
                    dec.gr_we       = 1'b1;
                    dst_is_rt       = 1'b1;
                end
            end
            id_pkg::OP_LW: begin
                dec.src2_is_imm = 1'b1;
                dec.load_op     = 1'b1;
                dec.gr_we       = 1'b1;
                dst_is_rt       = 1'b1;
            end
            id_pkg::OP_SW: begin
                dec.src2_is_imm = 1'b1;
                dec.mem_we      = 1'b1;
            end
            id_pkg::OP_BEQ: dec.branch = id_pkg::BR_BEQ;
            id_pkg::OP_BNE: dec.branch = id_pkg::BR_BNE;
            id_pkg::OP_JAL: begin
                // link value is pc + 8
                dec.src1_is_pc = 1'b1;
                dec.src2_is_8  = 1'b1;
                dec.gr_we      = 1'b1;
                dec.branch     = id_pkg::BR_JAL;
                dst_is_r31     = 1'b1;
            end
            default: ;
        endcase

        dec.dest = dst_is_r31 ? RA_REG :
                   dst_is_rt  ? rt     :
                                rd;
    end

endmodule

/* rtl/regfile.sv */
`timescale 1ns/1ps
`include "id_consts.svh"

module regfile (
    input  logic                      clk,
    input  logic [`ID_REG_ADDR_W-1:0] raddr1,
    input  logic [`ID_REG_ADDR_W-1:0] raddr2,
    output logic [`ID_XLEN-1:0]       rdata1,
    output logic [`ID_XLEN-1:0]       rdata2,
    input  id_pkg::reg_wr_t           wr
);

    logic [`ID_XLEN-1:0] regs [`ID_NUM_REGS];

    always_ff @(posedge clk) begin
        if (wr.we) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // r0 is hardwired, whatever was written there
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* rtl/id_pkg.sv */
`include "id_consts.svh"

package id_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_NOR,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_JAL,
        BR_JR
    } branch_kind_e;

    // pc sits in the low word
    typedef struct packed {
        logic [`ID_XLEN-1:0] inst;
        logic [`ID_XLEN-1:0] pc;
    } fs_to_ds_t;

    typedef struct packed {
        alu_op_e                   alu_op;
        logic                      src1_is_sa;
        logic                      src1_is_pc;
        logic                      src2_is_imm;
        logic                      src2_is_8;
        logic                      load_op;
        logic                      gr_we;
        logic                      mem_we;
        logic [`ID_REG_ADDR_W-1:0] dest;
        logic [`ID_IMM_W-1:0]      imm;
        logic [`ID_REG_ADDR_W-1:0] rs;
        logic [`ID_REG_ADDR_W-1:0] rt;
        branch_kind_e              branch;
        logic [`ID_JIDX_W-1:0]     jidx;
    } decode_t;

    typedef struct packed {
        logic                      we;
        logic [`ID_REG_ADDR_W-1:0] dest;
        logic [`ID_XLEN-1:0]       data;
        logic                      load_pending;
    } es_fwd_t;

    typedef struct packed {
        logic                      we;
        logic [`ID_REG_ADDR_W-1:0] addr;
        logic [`ID_XLEN-1:0]       data;
    } reg_wr_t;

    typedef struct packed {
        alu_op_e                   alu_op;
        logic                      src1_is_sa;
        logic                      src1_is_pc;
        logic                      src2_is_imm;
        logic                      src2_is_8;
        logic                      load_op;
        logic                      gr_we;
        logic                      mem_we;
        logic [`ID_REG_ADDR_W-1:0] dest;
        logic [`ID_IMM_W-1:0]      imm;
        logic [`ID_XLEN-1:0]       rs_value;
        logic [`ID_XLEN-1:0]       rt_value;
        logic [`ID_XLEN-1:0]       pc;
    } ds_to_es_t;

    typedef struct packed {
        logic                stall;
        logic                taken;
        logic [`ID_XLEN-1:0] target;
    } br_t;

endpackage

/* include/id_consts.svh */
`ifndef ID_CONSTS_SVH
`define ID_CONSTS_SVH

// datapath and instruction word width
`define ID_XLEN 32

// register file geometry
`define ID_REG_ADDR_W 5
`define ID_NUM_REGS 32

// jal writes its return address here
`define ID_RA_REG 31

// instruction field widths
`define ID_IMM_W 16
`define ID_JIDX_W 26

`endif
